// ==== vlog.f ====
+incdir+hw
hw/fft_data_pkg.sv
hw/fft_ctrl_pkg.sv
hw/fft_delay_line.sv
hw/fft_sequencer.sv
hw/fft_butterfly.sv
hw/fft_pingpong_mem.sv
hw/fft_top.sv
dv/fft_assert.sv
dv/fft_tb.sv

// ==== Bender.yml ====
package:
  name: fft8

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fft_data_pkg.sv
      - hw/fft_ctrl_pkg.sv
      - hw/fft_delay_line.sv
      - hw/fft_sequencer.sv
      - hw/fft_butterfly.sv
      - hw/fft_pingpong_mem.sv
      - hw/fft_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/fft_assert.sv
      - dv/fft_tb.sv

// ==== dv/fft_tb.sv ====
`timescale 1ns/1ps
`include "fft_settings.svh"

module fft_tb;

  logic                     clk;
  logic                     reset;
  logic                     load;
  fft_data_pkg::cplx_pair_t load_data;
  logic                     start;
  logic                     done;
  fft_ctrl_pkg::bin_addr_t  rd_addr;
  fft_data_pkg::cplx_t      rd_data;

  integer seed = 32'h5f62_965a;

  fft_top dut (
    .clk(clk),
    .reset(reset),
    .load(load),
    .load_data(load_data),
    .start(start),
    .done(done),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  bind fft_top fft_assert u_check (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // stop at the first failed assertion
  always @(posedge clk) begin
    if (dut.u_check.fail_count != 0) begin
      $display("Regression failed");
      $fatal(1, "an assertion in fft_assert failed");
    end
  end

  // small range keeps every sum inside Q8.8
  function automatic fft_data_pkg::sample_t random_sample();
    return fft_data_pkg::sample_t'($random(seed) % 17);
  endfunction

  task automatic load_frame();
    fft_data_pkg::cplx_pair_t pair;
    for (int k = 0; k < `FFT_N / 2; k++) begin
      pair.upper.re = random_sample();
      pair.upper.im = random_sample();
      pair.lower.re = random_sample();
      pair.lower.im = random_sample();
      @(posedge clk);
      load      <= 1'b1;
      load_data <= pair; // samples 2k and 2k+1
    end
    @(posedge clk);
    load <= 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (!done && cycles < `FFT_RUN_CYCLES + 16) begin
      @(posedge clk);
      cycles++;
    end
    if (!done) begin
      $display("timeout: done did not rise after start");
      $display("Regression failed");
      $fatal(1, "no done within %0d cycles", cycles);
    end
  endtask

  // up and back down, so bins 0 and 4 follow different neighbours
  task automatic read_sweep();
    for (int a = 0; a < `FFT_N; a++) begin
      @(posedge clk);
      rd_addr <= fft_ctrl_pkg::bin_addr_t'(a);
    end
    for (int a = `FFT_N - 1; a >= 0; a--) begin
      @(posedge clk);
      rd_addr <= fft_ctrl_pkg::bin_addr_t'(a);
    end
    @(posedge clk);
    rd_addr <= 3'd3; // park away from the checked bins
    @(posedge clk);
  endtask

  task automatic run_transform();
    load_frame();
    repeat (2) @(posedge clk);
    pulse_start();
    wait_done();
    read_sweep();
    repeat (10) @(posedge clk); // done must hold here
  endtask

  initial begin
    reset     = 1'b1;
    load      = 1'b0;
    load_data = '0;
    start     = 1'b0;
    rd_addr   = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    repeat (8) @(posedge clk); // idle, done stays low
    run_transform();
    run_transform(); // fresh data through the same banks

    repeat (4) @(posedge clk);
    if (dut.u_check.fail_count == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("Regression failed");
      $fatal(1, "%0d assertion failures", dut.u_check.fail_count);
    end
  end

endmodule

// ==== dv/fft_assert.sv ====
`timescale 1ns/1ps
`include "fft_settings.svh"

module fft_assert (
  input logic                     clk,
  input logic                     reset,
  input logic                     load,
  input fft_data_pkg::cplx_pair_t load_data,
  input logic                     start,
  input logic                     done,
  input fft_ctrl_pkg::bin_addr_t  rd_addr,
  input fft_data_pkg::cplx_t      rd_data
);

  localparam int run_cycles = `FFT_RUN_CYCLES;

  int                    fail_count = 0;
  int                    run_cnt;
  logic                  started;
  logic                  fresh; // next load begins a new frame
  fft_data_pkg::sample_t sum_re;
  fft_data_pkg::sample_t sum_im;
  fft_data_pkg::sample_t alt_re;
  fft_data_pkg::sample_t alt_im;

  // reference sums for bin 0 and bin 4, wrapping like Q8.8
  always_ff @(posedge clk) begin
    if (reset) begin
      run_cnt <= 0;
      started <= 1'b0;
      fresh   <= 1'b1;
      sum_re  <= '0;
      sum_im  <= '0;
      alt_re  <= '0;
      alt_im  <= '0;
    end else begin
      if (load && run_cnt == 0) begin
        sum_re <= (fresh ? '0 : sum_re) + load_data.upper.re + load_data.lower.re;
        sum_im <= (fresh ? '0 : sum_im) + load_data.upper.im + load_data.lower.im;
        alt_re <= (fresh ? '0 : alt_re) + load_data.upper.re - load_data.lower.re;
        alt_im <= (fresh ? '0 : alt_im) + load_data.upper.im - load_data.lower.im;
        fresh  <= 1'b0;
      end
      if (start && run_cnt == 0) begin
        started <= 1'b1;
        run_cnt <= run_cycles; // start is ignored until this drains
        fresh   <= 1'b1;
      end else if (run_cnt != 0) begin
        run_cnt <= run_cnt - 1;
      end
    end
  end

  done_idle: assert property (@(posedge clk) disable iff (reset) !started |-> !done)
    else begin
      $error("done is high although no transform was started");
      fail_count++;
    end

  done_timing: assert property (@(posedge clk) disable iff (reset)
      start && !done && run_cnt == 0 |=> !done [*run_cycles] ##1 done)
    else begin
      $error("done did not rise exactly %0d cycles after start", run_cycles);
      fail_count++;
    end

  done_hold: assert property (@(posedge clk) disable iff (reset) done && !load |=> done)
    else begin
      $error("done dropped before the next load");
      fail_count++;
    end

  done_clear: assert property (@(posedge clk) disable iff (reset) load |=> !done)
    else begin
      $error("done still high after a load");
      fail_count++;
    end

  bin0_re: assert property (@(posedge clk) disable iff (reset)
      done && !load && rd_addr == 3'd0 |=> rd_data.re == sum_re)
    else begin
      $error("[FAIL] %0t rd_data.re bin 0 got %0d expected %0d",
             $time, $sampled(rd_data.re), $sampled(sum_re));
      fail_count++;
    end

  bin0_im: assert property (@(posedge clk) disable iff (reset)
      done && !load && rd_addr == 3'd0 |=> rd_data.im == sum_im)
    else begin
      $error("[FAIL] %0t rd_data.im bin 0 got %0d expected %0d",
             $time, $sampled(rd_data.im), $sampled(sum_im));
      fail_count++;
    end

  bin4_re: assert property (@(posedge clk) disable iff (reset)
      done && !load && rd_addr == 3'd4 |=> rd_data.re == alt_re)
    else begin
      $error("[FAIL] %0t rd_data.re bin 4 got %0d expected %0d",
             $time, $sampled(rd_data.re), $sampled(alt_re));
      fail_count++;
    end

  bin4_im: assert property (@(posedge clk) disable iff (reset)
      done && !load && rd_addr == 3'd4 |=> rd_data.im == alt_im)
    else begin
      $error("[FAIL] %0t rd_data.im bin 4 got %0d expected %0d",
             $time, $sampled(rd_data.im), $sampled(alt_im));
      fail_count++;
    end

endmodule

// ==== hw/fft_top.sv ====
`timescale 1ns/1ps

module fft_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load,
  input  fft_data_pkg::cplx_pair_t load_data,
  input  logic                     start,
  output logic                     done,
  input  fft_ctrl_pkg::bin_addr_t  rd_addr,
  output fft_data_pkg::cplx_t      rd_data
);

  logic                       load_active;
  logic                       bank_sel;
  fft_ctrl_pkg::wr_cmd_t      load_wr;
  fft_ctrl_pkg::wr_cmd_t      bfly_wr;
  fft_ctrl_pkg::wr_cmd_t      res_wr;
  fft_ctrl_pkg::addr_pair_t   rd_pair;
  fft_ctrl_pkg::twiddle_idx_t twiddle_idx;
  fft_data_pkg::cplx_pair_t   operands;
  fft_data_pkg::cplx_pair_t   results;

  fft_sequencer u_sequencer (
    .clk(clk),
    .reset(reset),
    .load(load),
    .start(start),
    .done(done),
    .load_active(load_active),
    .load_wr(load_wr),
    .rd_pair(rd_pair),
    .bank_sel(bank_sel),
    .twiddle_idx(twiddle_idx),
    .bfly_wr(bfly_wr)
  );

  fft_pingpong_mem u_mem (
    .clk(clk),
    .reset(reset),
    .load_active(load_active),
    .load_wr(load_wr),
    .load_data(load_data),
    .rd_pair(rd_pair),
    .bank_sel(bank_sel),
    .res_wr(res_wr),
    .results(results),
    .operands(operands),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  fft_butterfly u_butterfly (
    .clk(clk),
    .reset(reset),
    .operands(operands),
    .twiddle_idx(twiddle_idx),
    .bfly_wr(bfly_wr),
    .results(results),
    .res_wr(res_wr)
  );

endmodule

// ==== hw/fft_pingpong_mem.sv ====
`timescale 1ns/1ps
`include "fft_settings.svh"

module fft_pingpong_mem (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load_active,
  input  fft_ctrl_pkg::wr_cmd_t    load_wr,
  input  fft_data_pkg::cplx_pair_t load_data,
  input  fft_ctrl_pkg::addr_pair_t rd_pair,
  input  logic                     bank_sel,
  input  fft_ctrl_pkg::wr_cmd_t    res_wr,
  input  fft_data_pkg::cplx_pair_t results,
  output fft_data_pkg::cplx_pair_t operands,
  input  fft_ctrl_pkg::bin_addr_t  rd_addr,
  output fft_data_pkg::cplx_t      rd_data
);

  localparam int banks = 2;

  fft_data_pkg::cplx_t      bank [banks][`FFT_N];
  logic [banks-1:0]         wr_en;
  fft_ctrl_pkg::addr_pair_t wr_addr [banks];
  fft_data_pkg::cplx_pair_t wr_data [banks];

  // write side of each bank
  always_comb begin
    for (int b = 0; b < banks; b++) begin
      wr_en[b]   = res_wr.valid && !load_active && (bank_sel != 1'(b));
      wr_addr[b] = res_wr.addr;
      wr_data[b] = results;
    end
    if (load_active) begin
      wr_en[0]   = load_wr.valid; // external samples go to bank 0 only
      wr_addr[0] = load_wr.addr;
      wr_data[0] = load_data;
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < banks; b++) begin
      if (wr_en[b]) begin
        bank[b][wr_addr[b].upper] <= wr_data[b].upper;
        bank[b][wr_addr[b].lower] <= wr_data[b].lower;
      end
    end
  end

  // operand reads from the selected bank, result port on bank 1
  always_ff @(posedge clk) begin
    if (reset) begin
      operands <= '0;
      rd_data  <= '0;
    end else begin
      operands.upper <= bank[bank_sel][rd_pair.upper];
      operands.lower <= bank[bank_sel][rd_pair.lower];
      rd_data        <= bank[1][rd_addr]; // final stage lands in bank 1
    end
  end

endmodule

// ==== hw/fft_butterfly.sv ====
`timescale 1ns/1ps
`include "fft_settings.svh"

module fft_butterfly (
  input  logic                       clk,
  input  logic                       reset,
  input  fft_data_pkg::cplx_pair_t   operands,
  input  fft_ctrl_pkg::twiddle_idx_t twiddle_idx,
  input  fft_ctrl_pkg::wr_cmd_t      bfly_wr,
  output fft_data_pkg::cplx_pair_t   results,
  output fft_ctrl_pkg::wr_cmd_t      res_wr
);

  localparam int w = `FFT_INT_BITS + `FFT_FRAC_BITS;
  localparam int f = `FFT_FRAC_BITS;

  typedef logic signed [2*w-1:0] prod_t;

  fft_ctrl_pkg::twiddle_idx_t idx_q;
  fft_data_pkg::cplx_t        odd_q;
  fft_data_pkg::cplx_t        odd_qq;
  fft_data_pkg::cplx_t        tw_q;
  prod_t                      p_rr, p_ii, p_ri, p_ir;
  fft_data_pkg::sample_t      t_rr, t_ii, t_ri, t_ir;
  fft_data_pkg::cplx_t        prod_q;
  fft_data_pkg::cplx_t        even_d;

  function automatic fft_data_pkg::cplx_t twiddle_rom(fft_ctrl_pkg::twiddle_idx_t idx);
    fft_data_pkg::cplx_t tw;
    case (idx)
      2'd0:    tw = '{re: 16'sh0100, im: 16'sh0000}; // 1
      2'd1:    tw = '{re: 16'sh00b5, im: 16'shff4b}; // (1 - j) / sqrt 2
      2'd2:    tw = '{re: 16'sh0000, im: 16'shff00}; // -j
      default: tw = '{re: 16'shff4b, im: 16'shff4b};
    endcase
    return tw;
  endfunction

  // add half an lsb, then cut back to Q8.8
  function automatic fft_data_pkg::sample_t round_q(prod_t p);
    prod_t r;
    r = p + (prod_t'(1) <<< (f - 1));
    return r[w+f-1:f];
  endfunction

  always_ff @(posedge clk) begin
    idx_q  <= twiddle_idx;
    odd_q  <= operands.lower;
    tw_q   <= twiddle_rom(idx_q); // registered table read
    odd_qq <= odd_q;
    p_rr   <= odd_qq.re * tw_q.re;
    p_ii   <= odd_qq.im * tw_q.im;
    p_ri   <= odd_qq.re * tw_q.im;
    p_ir   <= odd_qq.im * tw_q.re;
    t_rr   <= round_q(p_rr);
    t_ii   <= round_q(p_ii);
    t_ri   <= round_q(p_ri);
    t_ir   <= round_q(p_ir);
    prod_q.re <= t_rr - t_ii;
    prod_q.im <= t_ri + t_ir;
    results.upper.re <= even_d.re + prod_q.re; // wraps on overflow
    results.upper.im <= even_d.im + prod_q.im;
    results.lower.re <= even_d.re - prod_q.re;
    results.lower.im <= even_d.im - prod_q.im;
  end

  // even operand meets the product one cycle before the result
  fft_delay_line #(
    .payload_t(fft_data_pkg::cplx_t),
    .depth(`FFT_BFLY_LATENCY - 1)
  ) u_even_delay (
    .clk(clk),
    .reset(reset),
    .in(operands.upper),
    .out(even_d)
  );

  fft_delay_line #(
    .payload_t(fft_ctrl_pkg::wr_cmd_t),
    .depth(`FFT_BFLY_LATENCY)
  ) u_wr_delay (
    .clk(clk),
    .reset(reset),
    .in(bfly_wr),
    .out(res_wr)
  );

endmodule

// ==== hw/fft_sequencer.sv ====
`timescale 1ns/1ps
`include "fft_settings.svh"

module fft_sequencer (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       load,
  input  logic                       start,
  output logic                       done,
  output logic                       load_active,
  output fft_ctrl_pkg::wr_cmd_t      load_wr,
  output fft_ctrl_pkg::addr_pair_t   rd_pair,
  output logic                       bank_sel,
  output fft_ctrl_pkg::twiddle_idx_t twiddle_idx,
  output fft_ctrl_pkg::wr_cmd_t      bfly_wr
);

  localparam int cyc_w = $clog2(`FFT_PAIR_CYCLES);
  localparam int pairs = `FFT_N / 2;
  localparam int pair_w = $clog2(pairs);
  localparam int last_stage = `FFT_STAGES - 1;

  logic                     running;
  logic [cyc_w-1:0]         cyc;
  logic [pair_w-1:0]        pair;
  logic [pair_w-1:0]        load_cnt;
  fft_ctrl_pkg::stage_t     stage;
  fft_ctrl_pkg::bin_addr_t  nat_upper;
  fft_ctrl_pkg::bin_addr_t  nat_lower;
  fft_ctrl_pkg::addr_pair_t wr_pair;
  logic                     slot_end;
  logic                     pair_last;
  logic                     stage_last;

  function automatic fft_ctrl_pkg::bin_addr_t bit_rev(fft_ctrl_pkg::bin_addr_t a);
    fft_ctrl_pkg::bin_addr_t r;
    for (int i = 0; i < $bits(a); i++) begin
      r[i] = a[$bits(a)-1-i];
    end
    return r;
  endfunction

  function automatic fft_ctrl_pkg::bin_addr_t rot_left(fft_ctrl_pkg::bin_addr_t a,
                                                       fft_ctrl_pkg::stage_t s);
    logic [2*$bits(a)-1:0] d;
    d = {a, a} << s;
    return d[2*$bits(a)-1 -: $bits(a)];
  endfunction

  assign slot_end   = (cyc == cyc_w'(`FFT_PAIR_CYCLES - 1));
  assign pair_last  = (pair == pair_w'(pairs - 1));
  assign stage_last = (stage == fft_ctrl_pkg::stage_t'(last_stage));

  assign nat_upper = {pair, 1'b0};
  assign nat_lower = {pair, 1'b1};

  // stage 0 reads bit-reversed, later stages rotate with the stage
  assign rd_pair.upper = (stage == '0) ? bit_rev(nat_upper) : rot_left(nat_upper, stage);
  assign rd_pair.lower = (stage == '0) ? bit_rev(nat_lower) : rot_left(nat_lower, stage);
  assign wr_pair.upper = rot_left(nat_upper, stage); // natural order in stage 0
  assign wr_pair.lower = rot_left(nat_lower, stage);

  // keep only the pair bits that grow with the stage
  assign twiddle_idx = pair &
      ~fft_ctrl_pkg::twiddle_idx_t'((1 << (last_stage - int'(stage))) - 1);

  assign load_active   = ~running;
  assign load_wr.valid = load & ~running;
  assign load_wr.addr  = '{upper: {load_cnt, 1'b0}, lower: {load_cnt, 1'b1}};

  always_ff @(posedge clk) begin
    if (reset) begin
      running  <= 1'b0;
      cyc      <= '0;
      pair     <= '0;
      stage    <= '0;
      load_cnt <= '0;
      bank_sel <= 1'b0;
      done     <= 1'b0;
      bfly_wr  <= '0;
    end else begin
      bfly_wr <= '0;
      if (load && !running) begin
        load_cnt <= load_cnt + 1'b1;
        done     <= 1'b0;
      end
      if (start && !running) begin
        running  <= 1'b1;
        cyc      <= '0;
        pair     <= '0;
        stage    <= '0;
        load_cnt <= '0;
        bank_sel <= 1'b0; // bank 0 holds the loaded samples
      end else if (running) begin
        if (cyc == '0) begin
          bfly_wr.valid <= 1'b1; // lines up with operands
          bfly_wr.addr  <= wr_pair;
        end
        cyc <= slot_end ? '0 : cyc + 1'b1;
        if (slot_end) begin
          pair <= pair + 1'b1;
          if (pair_last) begin
            stage    <= stage + 1'b1;
            bank_sel <= ~bank_sel;
            if (stage_last) begin
              stage   <= '0;
              running <= 1'b0;
              done    <= 1'b1;
            end
          end
        end
      end
    end
  end

endmodule

// ==== hw/fft_delay_line.sv ====
`timescale 1ns/1ps

module fft_delay_line #(
  parameter type payload_t = logic,
  parameter int depth = 1
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t in,
  output payload_t out
);

  payload_t chain [depth];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        chain[i] <= '0;
      end
    end else begin
      chain[0] <= in;
      for (int i = 1; i < depth; i++) begin
        chain[i] <= chain[i-1];
      end
    end
  end

  assign out = chain[depth-1];

endmodule

// ==== hw/fft_ctrl_pkg.sv ====
`include "fft_settings.svh"

package fft_ctrl_pkg;

  typedef logic [$clog2(`FFT_N)-1:0] bin_addr_t;

  typedef struct packed {
    bin_addr_t upper;
    bin_addr_t lower;
  } addr_pair_t;

  typedef logic [$clog2(`FFT_STAGES)-1:0] stage_t;

  // w8^0 .. w8^3
  typedef logic [$clog2(`FFT_N/2)-1:0] twiddle_idx_t;

  typedef struct packed {
    logic       valid;
    addr_pair_t addr;
  } wr_cmd_t;

endpackage

// ==== hw/fft_data_pkg.sv ====
`include "fft_settings.svh"

package fft_data_pkg;

  // one Q8.8 word
  typedef logic signed [`FFT_INT_BITS+`FFT_FRAC_BITS-1:0] sample_t;

  typedef struct packed {
    sample_t re;
    sample_t im;
  } cplx_t;

  // butterfly operands or results
  typedef struct packed {
    cplx_t upper; // even input, sum output
    cplx_t lower; // odd input, difference output
  } cplx_pair_t;

endpackage

// ==== hw/fft_settings.svh ====
`ifndef FFT_SETTINGS_SVH
`define FFT_SETTINGS_SVH

// transform size
`define FFT_N 8

// Q8.8 sample format
`define FFT_INT_BITS 8
`define FFT_FRAC_BITS 8

// one butterfly pair per slot
`define FFT_PAIR_CYCLES 8

// log2 of FFT_N
`define FFT_STAGES 3

// start sampled to done high, stages * pairs * slot
`define FFT_RUN_CYCLES 96

// operands in to results out
`define FFT_BFLY_LATENCY 6

`endif
